// ==== verilog.f ====
verilog/reconfig_pkg.sv
verilog/mgmt_wait_timer.sv
verilog/reconfig_ram.sv
verilog/busy_regs.sv
verilog/reconfig_sequencer.sv
verilog/reconfig_soc.sv
sim/clk_gen.sv
sim/tb_reconfig_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1

TOP=tb_reconfig_soc
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== sim/tb_reconfig_soc.sv ====
// Directed tests only; basic model and grant model use $urandom, so a run repeats for one seed
module tb_reconfig_soc;

  localparam int NUM_TESTS       = 7;
  localparam int CYCLES_PER_TEST = 200;
  localparam int RESET_CYCLES    = 10;
  localparam int WAIT_LIMIT      = 100;

  logic                                     mgmt_clk;
  logic                                     ctrl_reset;
  logic [reconfig_pkg::MGMT_ADDR_BITS-1:0]  mgmt_address;
  logic                                     mgmt_read;
  logic                                     mgmt_write;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      mgmt_writedata;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      mgmt_readdata;
  logic                                     mgmt_waitrequest;
  logic [reconfig_pkg::ARB_COUNT-1:0]       hold;
  logic [reconfig_pkg::ARB_COUNT-1:0]       busy;
  logic [reconfig_pkg::BASIC_ADDR_BITS-1:0] basic_address;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_writedata;
  logic                                     basic_write;
  logic                                     basic_read;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_readdata = '0;
  logic                                     basic_waitrequest = 1'b0;
  logic [reconfig_pkg::ARB_COUNT-1:0]       basic_req;
  logic [reconfig_pkg::ARB_COUNT-1:0]       basic_grant = '0;

  // Model state
  logic [reconfig_pkg::ARB_COUNT-1:0]       grant_en;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_regs [8];
  logic [reconfig_pkg::DATA_WIDTH-1:0]      exp_regs [8];
  int                                       access_count;
  int                                       wait_left;
  int                                       grant_delay;
  int                                       error_count = 0;
  int                                       protocol_errors = 0;

  clk_gen clk_gen_inst (
    .clk(mgmt_clk)
  );

  reconfig_soc reconfig_soc_inst (
    .mgmt_clk         (mgmt_clk),
    .ctrl_reset       (ctrl_reset),
    .mgmt_address     (mgmt_address),
    .mgmt_read        (mgmt_read),
    .mgmt_write       (mgmt_write),
    .mgmt_writedata   (mgmt_writedata),
    .mgmt_readdata    (mgmt_readdata),
    .mgmt_waitrequest (mgmt_waitrequest),
    .hold             (hold),
    .busy             (busy),
    .basic_address    (basic_address),
    .basic_writedata  (basic_writedata),
    .basic_write      (basic_write),
    .basic_read       (basic_read),
    .basic_readdata   (basic_readdata),
    .basic_waitrequest(basic_waitrequest),
    .basic_req        (basic_req),
    .basic_grant      (basic_grant)
  );

  // ********************
  // Helpers for addresses and command words
  function automatic logic [31:0] fill_word(input logic [2:0] addr);
    // Every address gets its own start value
    return (32'h1000_0001 * ({29'b0, addr} + 32'd1)) ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [reconfig_pkg::MGMT_ADDR_BITS-1:0] word_addr(
    input logic [reconfig_pkg::ARB_IDX_BITS-1:0] ip,
    input logic [reconfig_pkg::IP_ADDR_BITS-1:0] word);
    return {ip, word};
  endfunction

  function automatic logic [31:0] cmd_word(input reconfig_pkg::opcode_e op,
                                           input logic [2:0] addr);
    logic [31:0] w;
    w = '0;
    w[reconfig_pkg::CMD_OP_LSB +: reconfig_pkg::OP_BITS] = op;
    w[2:0] = addr;
    return w;
  endfunction

  function automatic logic [reconfig_pkg::ARB_COUNT-1:0] ip_mask(
    input logic [reconfig_pkg::ARB_IDX_BITS-1:0] ip);
    return 4'b0001 << ip;
  endfunction

  // ********************
  // Basic block model with 8 registers and 0 to 3 wait cycles per access
  always @(posedge mgmt_clk) begin
    if (ctrl_reset) begin
      for (int i = 0; i < 8; i++) begin
        basic_regs[i] <= fill_word(i[2:0]);
      end
      access_count      <= 0;
      wait_left          = 0;
      basic_waitrequest <= 1'b0;
    end else begin
      // Address is stable from FETCH_DATA on, so readdata is ready by ACCESS
      basic_readdata <= basic_regs[basic_address];
      if (basic_read || basic_write) begin
        if (!basic_waitrequest) begin
          if (basic_write) begin
            basic_regs[basic_address] <= basic_writedata;
          end
          access_count <= access_count + 1;
          // Wait for the next access picked here
          wait_left = $urandom % 4;
        end else begin
          wait_left = wait_left - 1;
        end
        basic_waitrequest <= (wait_left != 0);
      end
    end
  end

  // Grant model answers one request after 0 to 5 cycles while enabled
  always @(posedge mgmt_clk) begin
    if (basic_req == '0) begin
      basic_grant <= '0;
      grant_delay  = $urandom % 6;
    end else if ((basic_req & grant_en) != '0) begin
      if (grant_delay == 0) begin
        basic_grant <= basic_req & grant_en;
      end else begin
        grant_delay = grant_delay - 1;
      end
    end
  end

  // Protocol monitor on the request/grant pair
  always @(negedge mgmt_clk) begin
    if (!ctrl_reset) begin
      if ((basic_req & (basic_req - 4'd1)) != '0) begin
        $display("Error at %0t: more than one basic_req bit high (%b)", $time, basic_req);
        protocol_errors++;
      end
      if ((basic_read || basic_write) && ((basic_grant & basic_req) == '0)) begin
        $display("Error at %0t: basic access without a grant for its IP", $time);
        protocol_errors++;
      end
    end
  end

  // ********************
  // Compare tasks
  task automatic check_word(input string name,
                            input logic [reconfig_pkg::DATA_WIDTH-1:0] expected,
                            input logic [reconfig_pkg::DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_busy(input logic [reconfig_pkg::ARB_COUNT-1:0] expected,
                            input logic [reconfig_pkg::ARB_COUNT-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: busy expected %b, got %b", $time, expected, actual);
      error_count++;
    end
  endtask

  // ********************
  // Management port and control inputs
  task automatic mgmt_wr(input logic [reconfig_pkg::MGMT_ADDR_BITS-1:0] addr,
                         input logic [reconfig_pkg::DATA_WIDTH-1:0] data);
    @(posedge mgmt_clk);
    mgmt_address   <= addr;
    mgmt_writedata <= data;
    mgmt_write     <= 1'b1;
    // Write never waits
    @(posedge mgmt_clk);
    mgmt_write <= 1'b0;
  endtask

  task automatic mgmt_rd(input logic [reconfig_pkg::MGMT_ADDR_BITS-1:0] addr,
                         output logic [reconfig_pkg::DATA_WIDTH-1:0] data);
    int cycles;
    cycles = 0;
    data   = '0;
    @(posedge mgmt_clk);
    mgmt_address <= addr;
    mgmt_read    <= 1'b1;
    @(negedge mgmt_clk);
    while (mgmt_waitrequest && (cycles < WAIT_LIMIT)) begin
      @(negedge mgmt_clk);
      cycles++;
    end
    if (mgmt_waitrequest) begin
      $display("Error at %0t: management read never completed", $time);
      error_count++;
    end else begin
      data = mgmt_readdata;
      if (cycles != int'(reconfig_pkg::READ_WAIT_CYCLES)) begin
        $display("Error at %0t: management read waited %0d cycles", $time, cycles);
        error_count++;
      end
    end
    @(posedge mgmt_clk);
    mgmt_read <= 1'b0;
  endtask

  task automatic set_hold(input logic [reconfig_pkg::ARB_COUNT-1:0] value);
    @(posedge mgmt_clk);
    hold <= value;
  endtask

  task automatic set_grant_enable(input logic [reconfig_pkg::ARB_COUNT-1:0] value);
    @(posedge mgmt_clk);
    grant_en <= value;
  endtask

  task automatic wait_busy_clear(input logic [reconfig_pkg::ARB_COUNT-1:0] mask,
                                 input string what);
    int cycles;
    cycles = 0;
    @(negedge mgmt_clk);
    while (((busy & mask) != '0) && (cycles < WAIT_LIMIT)) begin
      @(negedge mgmt_clk);
      cycles++;
    end
    if ((busy & mask) != '0) begin
      $display("Error at %0t: %s still busy after %0d cycles", $time, what, WAIT_LIMIT);
      error_count++;
    end
  endtask

  task automatic wait_req(input logic [reconfig_pkg::ARB_IDX_BITS-1:0] ip);
    int cycles;
    cycles = 0;
    @(negedge mgmt_clk);
    while (!basic_req[ip] && (cycles < WAIT_LIMIT)) begin
      @(negedge mgmt_clk);
      cycles++;
    end
    if (!basic_req[ip]) begin
      $display("Error at %0t: IP %0d never requested the basic block", $time, ip);
      error_count++;
    end
  endtask

  task automatic load_cmd(input logic [reconfig_pkg::ARB_IDX_BITS-1:0] ip,
                          input reconfig_pkg::opcode_e op,
                          input logic [2:0] addr,
                          input logic [reconfig_pkg::DATA_WIDTH-1:0] data);
    mgmt_wr(word_addr(ip, reconfig_pkg::WORD_CMD), cmd_word(op, addr));
    mgmt_wr(word_addr(ip, reconfig_pkg::WORD_DATA), data);
  endtask

  // Any status value starts the command
  task automatic start_cmd(input logic [reconfig_pkg::ARB_IDX_BITS-1:0] ip);
    logic [31:0] r;
    r = $urandom;
    mgmt_wr(word_addr(ip, reconfig_pkg::WORD_STATUS), r);
  endtask

  // ********************
  // Tests
  task automatic expect_reset_outputs();
    @(negedge mgmt_clk);
    check_busy('0, busy);
    check_word("basic_req", 32'd0, 32'(basic_req));
    check_word("read, write, waitrequest", 32'd0,
               32'({basic_read, basic_write, mgmt_waitrequest}));
  endtask

  task automatic readback_words();
    logic [reconfig_pkg::ARB_IDX_BITS-1:0] ip;
    logic [31:0]                           d_cmd;
    logic [31:0]                           d_data;
    logic [31:0]                           d_result;
    logic [31:0]                           d_status;
    logic [31:0]                           expected;
    logic [31:0]                           rd;
    for (int i = 0; i < reconfig_pkg::ARB_COUNT; i++) begin
      ip    = i[1:0];
      d_cmd = $urandom;
      // No-op command, so the status write below touches no basic register
      d_cmd[reconfig_pkg::CMD_OP_LSB +: reconfig_pkg::OP_BITS] = reconfig_pkg::OP_NONE;
      d_data   = $urandom;
      d_result = $urandom;
      mgmt_wr(word_addr(ip, reconfig_pkg::WORD_CMD), d_cmd);
      mgmt_wr(word_addr(ip, reconfig_pkg::WORD_DATA), d_data);
      mgmt_wr(word_addr(ip, reconfig_pkg::WORD_RESULT), d_result);
      mgmt_rd(word_addr(ip, reconfig_pkg::WORD_CMD), rd);
      check_word($sformatf("ip%0d cmd word", i), d_cmd, rd);
      mgmt_rd(word_addr(ip, reconfig_pkg::WORD_DATA), rd);
      check_word($sformatf("ip%0d data word", i), d_data, rd);
      mgmt_rd(word_addr(ip, reconfig_pkg::WORD_RESULT), rd);
      check_word($sformatf("ip%0d result word", i), d_result, rd);
      // Held IP keeps busy high for the status readback
      set_hold(ip_mask(ip));
      d_status = $urandom;
      mgmt_wr(word_addr(ip, reconfig_pkg::WORD_STATUS), d_status);
      mgmt_rd(word_addr(ip, reconfig_pkg::WORD_STATUS), rd);
      expected = d_status;
      expected[reconfig_pkg::STATUS_BUSY_BIT] = 1'b1;
      check_word($sformatf("ip%0d status while busy", i), expected, rd);
      check_busy(ip_mask(ip), busy);
      set_hold('0);
      wait_busy_clear(ip_mask(ip), "readback IP");
      mgmt_rd(word_addr(ip, reconfig_pkg::WORD_STATUS), rd);
      expected[reconfig_pkg::STATUS_BUSY_BIT] = 1'b0;
      check_word($sformatf("ip%0d status when idle", i), expected, rd);
      // OP_NONE leaves the result word alone
      mgmt_rd(word_addr(ip, reconfig_pkg::WORD_RESULT), rd);
      check_word($sformatf("ip%0d result after no-op", i), d_result, rd);
    end
  endtask

  task automatic write_through_basic();
    logic [31:0] r;
    logic [2:0]  addr;
    logic [31:0] data;
    int          snap;
    r    = $urandom;
    addr = r[2:0];
    data = $urandom;
    snap = access_count;
    load_cmd(2'd1, reconfig_pkg::OP_WRITE, addr, data);
    start_cmd(2'd1);
    @(negedge mgmt_clk);
    check_busy(4'b0010, busy);
    wait_busy_clear(4'b0010, "IP 1 write");
    exp_regs[addr] = data;
    check_word("basic register after write", exp_regs[addr], basic_regs[addr]);
    check_word("basic access count", snap + 1, access_count);
  endtask

  task automatic read_through_basic();
    logic [31:0] r;
    logic [2:0]  addr;
    logic [31:0] rd;
    r    = $urandom;
    addr = r[2:0];
    load_cmd(2'd2, reconfig_pkg::OP_READ, addr, 32'h0);
    start_cmd(2'd2);
    wait_busy_clear(4'b0100, "IP 2 read");
    mgmt_rd(word_addr(2'd2, reconfig_pkg::WORD_RESULT), rd);
    check_word("ip2 result word", exp_regs[addr], rd);
  endtask

  task automatic withhold_grant();
    logic [31:0] r;
    logic [2:0]  addr;
    logic [31:0] data;
    logic [31:0] rd;
    r    = $urandom;
    addr = r[2:0];
    data = $urandom;
    set_grant_enable(4'b0111);
    load_cmd(2'd3, reconfig_pkg::OP_WRITE, addr, data);
    start_cmd(2'd3);
    wait_req(2'd3);
    // Both writes hit a busy IP
    mgmt_wr(word_addr(2'd3, reconfig_pkg::WORD_CMD),
            cmd_word(reconfig_pkg::OP_READ, addr ^ 3'd1));
    mgmt_wr(word_addr(2'd3, reconfig_pkg::WORD_DATA), ~data);
    mgmt_rd(word_addr(2'd3, reconfig_pkg::WORD_CMD), rd);
    check_word("ip3 cmd word while busy", cmd_word(reconfig_pkg::OP_WRITE, addr), rd);
    mgmt_rd(word_addr(2'd3, reconfig_pkg::WORD_DATA), rd);
    check_word("ip3 data word while busy", data, rd);
    check_busy(4'b1000, busy);
    set_grant_enable('1);
    wait_busy_clear(4'b1000, "IP 3 after grant");
    exp_regs[addr] = data;
    check_word("basic register after late grant", exp_regs[addr], basic_regs[addr]);
  endtask

  task automatic hold_one_ip();
    logic [31:0] r;
    logic [2:0]  addr;
    logic [31:0] data;
    int          snap;
    r    = $urandom;
    addr = r[2:0];
    data = $urandom;
    set_hold(4'b0001);
    load_cmd(2'd0, reconfig_pkg::OP_NONE, addr ^ 3'd2, ~data);
    load_cmd(2'd1, reconfig_pkg::OP_WRITE, addr, data);
    start_cmd(2'd0);
    start_cmd(2'd1);
    wait_busy_clear(4'b0010, "IP 1 next to held IP 0");
    check_busy(4'b0001, busy);
    exp_regs[addr] = data;
    check_word("basic register from IP 1", exp_regs[addr], basic_regs[addr]);
    snap = access_count;
    set_hold('0);
    wait_busy_clear(4'b0001, "IP 0 after hold release");
    // No-op must not reach the basic block
    check_word("basic access count after no-op", snap, access_count);
  endtask

  task automatic serve_all_ips();
    logic [31:0] r;
    logic [2:0]  addrs [4];
    logic [31:0] datas [4];
    logic [31:0] rd;
    r = $urandom;
    // Even IPs write and odd IPs read four distinct registers
    for (int k = 0; k < 4; k++) begin
      addrs[k] = r[2:0] + k[2:0];
      datas[k] = $urandom;
      if (k[0]) begin
        load_cmd(k[1:0], reconfig_pkg::OP_READ, addrs[k], datas[k]);
      end else begin
        load_cmd(k[1:0], reconfig_pkg::OP_WRITE, addrs[k], datas[k]);
      end
    end
    for (int k = 0; k < 4; k++) begin
      start_cmd(k[1:0]);
    end
    wait_busy_clear('1, "all IPs");
    for (int k = 0; k < 4; k++) begin
      if (k[0]) begin
        mgmt_rd(word_addr(k[1:0], reconfig_pkg::WORD_RESULT), rd);
        check_word($sformatf("ip%0d read result", k), exp_regs[addrs[k]], rd);
      end else begin
        exp_regs[addrs[k]] = datas[k];
        check_word($sformatf("ip%0d written register", k), exp_regs[addrs[k]],
                   basic_regs[addrs[k]]);
      end
    end
  endtask

  // ********************
  // Main sequence
  initial begin
    void'($urandom(38));
    ctrl_reset     = 1'b1;
    mgmt_address   = '0;
    mgmt_read      = 1'b0;
    mgmt_write     = 1'b0;
    mgmt_writedata = '0;
    hold           = '0;
    grant_en       = '1;
    for (int i = 0; i < 8; i++) begin
      exp_regs[i] = fill_word(i[2:0]);
    end
    repeat (RESET_CYCLES) @(posedge mgmt_clk);
    ctrl_reset <= 1'b0;
    expect_reset_outputs();
    readback_words();
    write_through_basic();
    read_through_basic();
    withhold_grant();
    hold_one_ip();
    serve_all_ips();
    repeat (2) @(posedge mgmt_clk);
    $display("Summary: %0d check errors, %0d protocol errors", error_count, protocol_errors);
    if ((error_count + protocol_errors) == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the number of tests
  initial begin
    repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge mgmt_clk);
    $display("Timeout: tests still running after %0d cycles",
             RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sim/clk_gen.sv ====
// Free-running clock that starts low with a period of 10 time units and never stops
module clk_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

// ==== verilog/reconfig_soc.sv ====
// Writes to a busy IP's words are dropped; reads must hold the address until waitrequest falls
module reconfig_soc (
  input  logic                                     mgmt_clk,
  input  logic                                     ctrl_reset,
  // Management port
  input  logic [reconfig_pkg::MGMT_ADDR_BITS-1:0]  mgmt_address,
  input  logic                                     mgmt_read,
  input  logic                                     mgmt_write,
  input  logic [reconfig_pkg::DATA_WIDTH-1:0]      mgmt_writedata,
  output logic [reconfig_pkg::DATA_WIDTH-1:0]      mgmt_readdata,
  output logic                                     mgmt_waitrequest,
  // Per-IP sequencing
  input  logic [reconfig_pkg::ARB_COUNT-1:0]       hold,
  output logic [reconfig_pkg::ARB_COUNT-1:0]       busy,
  // Basic block
  output logic [reconfig_pkg::BASIC_ADDR_BITS-1:0] basic_address,
  output logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_writedata,
  output logic                                     basic_write,
  output logic                                     basic_read,
  input  logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_readdata,
  input  logic                                     basic_waitrequest,
  output logic [reconfig_pkg::ARB_COUNT-1:0]       basic_req,
  input  logic [reconfig_pkg::ARB_COUNT-1:0]       basic_grant
);

  logic [reconfig_pkg::ARB_IDX_BITS-1:0]  mgmt_ip;
  logic [reconfig_pkg::IP_ADDR_BITS-1:0]  mgmt_word;
  logic                                   mgmt_ram_write;
  logic                                   status_set;
  logic [reconfig_pkg::ARB_COUNT-1:0]     busy_vec;
  logic [reconfig_pkg::DATA_WIDTH-1:0]    mgmt_ram_rdata;
  logic [reconfig_pkg::RAM_ADDR_BITS-1:0] seq_ram_address;
  logic                                   seq_ram_write;
  logic [reconfig_pkg::DATA_WIDTH-1:0]    seq_ram_wdata;
  logic [reconfig_pkg::DATA_WIDTH-1:0]    seq_ram_rdata;
  logic                                   seq_clear;
  logic [reconfig_pkg::ARB_IDX_BITS-1:0]  seq_clear_idx;

  // ********************
  // Address decode
  assign mgmt_ip   = mgmt_address[reconfig_pkg::MGMT_ADDR_BITS-1 -: reconfig_pkg::ARB_IDX_BITS];
  assign mgmt_word = mgmt_address[reconfig_pkg::IP_ADDR_BITS-1:0];

  // Drop writes into an IP that the sequencer owns
  assign mgmt_ram_write = mgmt_write && !busy_vec[mgmt_ip];
  // Status write kicks off the command
  assign status_set     = mgmt_ram_write && (mgmt_word == reconfig_pkg::WORD_STATUS);

  assign busy = busy_vec;

  // Live busy bit replaces the stored one in a status readback
  always_comb begin
    mgmt_readdata = mgmt_ram_rdata;
    if (mgmt_word == reconfig_pkg::WORD_STATUS) begin
      mgmt_readdata[reconfig_pkg::STATUS_BUSY_BIT] = busy_vec[mgmt_ip];
    end
  end

  // ********************
  // Instances
  mgmt_wait_timer mgmt_wait_timer_inst (
    .mgmt_clk        (mgmt_clk),
    .ctrl_reset      (ctrl_reset),
    .mgmt_read       (mgmt_read),
    .mgmt_waitrequest(mgmt_waitrequest)
  );

  // Management address maps straight onto port B
  reconfig_ram reconfig_ram_inst (
    .mgmt_clk   (mgmt_clk),
    .a_address  (seq_ram_address),
    .a_write    (seq_ram_write),
    .a_writedata(seq_ram_wdata),
    .a_readdata (seq_ram_rdata),
    .b_address  (mgmt_address),
    .b_write    (mgmt_ram_write),
    .b_writedata(mgmt_writedata),
    .b_readdata (mgmt_ram_rdata)
  );

  busy_regs busy_regs_inst (
    .mgmt_clk    (mgmt_clk),
    .ctrl_reset  (ctrl_reset),
    .set_strobe  (status_set),
    .set_index   (mgmt_ip),
    .clear_strobe(seq_clear),
    .clear_index (seq_clear_idx),
    .busy        (busy_vec)
  );

  reconfig_sequencer reconfig_sequencer_inst (
    .mgmt_clk         (mgmt_clk),
    .ctrl_reset       (ctrl_reset),
    .busy             (busy_vec),
    .hold             (hold),
    .ram_address      (seq_ram_address),
    .ram_write        (seq_ram_write),
    .ram_writedata    (seq_ram_wdata),
    .ram_readdata     (seq_ram_rdata),
    .clear_strobe     (seq_clear),
    .clear_index      (seq_clear_idx),
    .basic_req        (basic_req),
    .basic_grant      (basic_grant),
    .basic_address    (basic_address),
    .basic_writedata  (basic_writedata),
    .basic_write      (basic_write),
    .basic_read       (basic_read),
    .basic_readdata   (basic_readdata),
    .basic_waitrequest(basic_waitrequest)
  );

endmodule

// ==== verilog/reconfig_sequencer.sv ====
// Grant must stay high through ACCESS; the busy IP's words are assumed stable while it runs
module reconfig_sequencer (
  input  logic                                     mgmt_clk,
  input  logic                                     ctrl_reset,
  input  logic [reconfig_pkg::ARB_COUNT-1:0]       busy,
  input  logic [reconfig_pkg::ARB_COUNT-1:0]       hold,
  // RAM port A
  output logic [reconfig_pkg::RAM_ADDR_BITS-1:0]   ram_address,
  output logic                                     ram_write,
  output logic [reconfig_pkg::DATA_WIDTH-1:0]      ram_writedata,
  input  logic [reconfig_pkg::DATA_WIDTH-1:0]      ram_readdata,
  // Busy clear
  output logic                                     clear_strobe,
  output logic [reconfig_pkg::ARB_IDX_BITS-1:0]    clear_index,
  // Arbitration for the basic block
  output logic [reconfig_pkg::ARB_COUNT-1:0]       basic_req,
  input  logic [reconfig_pkg::ARB_COUNT-1:0]       basic_grant,
  // Basic block access
  output logic [reconfig_pkg::BASIC_ADDR_BITS-1:0] basic_address,
  output logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_writedata,
  output logic                                     basic_write,
  output logic                                     basic_read,
  input  logic [reconfig_pkg::DATA_WIDTH-1:0]      basic_readdata,
  input  logic                                     basic_waitrequest
);

  reconfig_pkg::seq_state_e                 state;
  reconfig_pkg::opcode_e                    op_q;
  reconfig_pkg::opcode_e                    fetched_op;
  logic [reconfig_pkg::ARB_IDX_BITS-1:0]    cur_idx;
  logic [reconfig_pkg::ARB_IDX_BITS-1:0]    last_idx;
  logic [reconfig_pkg::ARB_IDX_BITS-1:0]    pick_idx;
  logic [reconfig_pkg::ARB_IDX_BITS-1:0]    probe;
  logic                                     pick_valid;
  logic [reconfig_pkg::ARB_COUNT-1:0]       cand;
  logic [reconfig_pkg::ARB_COUNT-1:0]       idx_onehot;
  logic                                     req_active;
  logic                                     granted;
  logic [reconfig_pkg::BASIC_ADDR_BITS-1:0] addr_q;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      data_q;
  logic [reconfig_pkg::DATA_WIDTH-1:0]      result_q;

  // ********************
  // Round robin pick
  assign cand = busy & ~hold;

  // Walk down from the farthest IP so the nearest one after last_idx wins
  always_comb begin
    pick_valid = 1'b0;
    pick_idx   = last_idx;
    probe      = last_idx;
    for (int i = reconfig_pkg::ARB_COUNT; i >= 1; i--) begin
      probe = last_idx + i[reconfig_pkg::ARB_IDX_BITS-1:0];
      if (cand[probe]) begin
        pick_valid = 1'b1;
        pick_idx   = probe;
      end
    end
  end

  // Command word shows on the RAM output while in FETCH_DATA
  assign fetched_op = reconfig_pkg::opcode_e'(
    ram_readdata[reconfig_pkg::CMD_OP_LSB +: reconfig_pkg::OP_BITS]);

  // ********************
  // Request and grant
  assign idx_onehot = {{(reconfig_pkg::ARB_COUNT-1){1'b0}}, 1'b1} << cur_idx;
  assign req_active = (state == reconfig_pkg::REQUEST) || (state == reconfig_pkg::ACCESS);
  assign basic_req  = req_active ? idx_onehot : '0;
  // Only the grant bit of our own IP counts
  assign granted    = |(idx_onehot & basic_grant);

  // ********************
  // FSM
  always_ff @(posedge mgmt_clk or posedge ctrl_reset) begin
    if (ctrl_reset) begin
      state    <= reconfig_pkg::IDLE;
      cur_idx  <= '0;
      last_idx <= '0;
    end else begin
      case (state)
        reconfig_pkg::IDLE: begin
          if (pick_valid) begin
            cur_idx <= pick_idx;
            state   <= reconfig_pkg::FETCH_CMD;
          end
        end
        reconfig_pkg::FETCH_CMD: state <= reconfig_pkg::FETCH_DATA;
        reconfig_pkg::FETCH_DATA: begin
          // No-op and spare opcodes never touch the basic block
          if ((fetched_op == reconfig_pkg::OP_WRITE) ||
              (fetched_op == reconfig_pkg::OP_READ)) begin
            state <= reconfig_pkg::REQUEST;
          end else begin
            state <= reconfig_pkg::DONE;
          end
        end
        reconfig_pkg::REQUEST: begin
          if (granted) begin
            state <= reconfig_pkg::ACCESS;
          end
        end
        reconfig_pkg::ACCESS: begin
          if (!basic_waitrequest) begin
            state <= (op_q == reconfig_pkg::OP_READ) ? reconfig_pkg::STORE
                                                     : reconfig_pkg::DONE;
          end
        end
        reconfig_pkg::STORE: state <= reconfig_pkg::DONE;
        reconfig_pkg::DONE: begin
          // Next scan starts after this IP
          last_idx <= cur_idx;
          state    <= reconfig_pkg::IDLE;
        end
        default: state <= reconfig_pkg::IDLE;
      endcase
    end
  end

  // ********************
  // Command payload
  always_ff @(posedge mgmt_clk) begin
    if (state == reconfig_pkg::FETCH_DATA) begin
      op_q   <= fetched_op;
      addr_q <= ram_readdata[reconfig_pkg::BASIC_ADDR_BITS-1:0];
    end
    // RAM address sits on WORD_DATA for the whole wait
    if (state == reconfig_pkg::REQUEST) begin
      data_q <= ram_readdata;
    end
    if ((state == reconfig_pkg::ACCESS) && !basic_waitrequest) begin
      result_q <= basic_readdata;
    end
  end

  // RAM port A word select
  always_comb begin
    case (state)
      reconfig_pkg::FETCH_CMD: ram_address = {cur_idx, reconfig_pkg::WORD_CMD};
      reconfig_pkg::STORE:     ram_address = {cur_idx, reconfig_pkg::WORD_RESULT};
      default:                 ram_address = {cur_idx, reconfig_pkg::WORD_DATA};
    endcase
  end

  assign ram_write     = (state == reconfig_pkg::STORE);
  assign ram_writedata = result_q;

  // Clear lands one edge after the result write
  assign clear_strobe = (state == reconfig_pkg::DONE);
  assign clear_index  = cur_idx;

  // Basic port, strobes only inside ACCESS
  assign basic_address   = addr_q;
  assign basic_writedata = data_q;
  assign basic_write     = (state == reconfig_pkg::ACCESS) && (op_q == reconfig_pkg::OP_WRITE);
  assign basic_read      = (state == reconfig_pkg::ACCESS) && (op_q == reconfig_pkg::OP_READ);

endmodule

// ==== verilog/busy_regs.sv ====
// One strobe of each kind per cycle; a set and a clear on the same bit leave it set
module busy_regs (
  input  logic                                  mgmt_clk,
  input  logic                                  ctrl_reset,
  input  logic                                  set_strobe,
  input  logic [reconfig_pkg::ARB_IDX_BITS-1:0] set_index,
  input  logic                                  clear_strobe,
  input  logic [reconfig_pkg::ARB_IDX_BITS-1:0] clear_index,
  output logic [reconfig_pkg::ARB_COUNT-1:0]    busy
);

  logic [reconfig_pkg::ARB_COUNT-1:0] set_vec;
  logic [reconfig_pkg::ARB_COUNT-1:0] clear_vec;

  // Decode the strobes into per-IP masks
  assign set_vec   = {{(reconfig_pkg::ARB_COUNT-1){1'b0}}, set_strobe} << set_index;
  assign clear_vec = {{(reconfig_pkg::ARB_COUNT-1){1'b0}}, clear_strobe} << clear_index;

  // ********************
  // Busy bits
  always_ff @(posedge mgmt_clk or posedge ctrl_reset) begin
    if (ctrl_reset) begin
      // Nothing pending out of reset
      busy <= '0;
    end else begin
      // Set applied after clear so it takes priority
      // Setting a bit that is already high changes nothing
      busy <= (busy & ~clear_vec) | set_vec;
    end
  end

endmodule

// ==== verilog/reconfig_ram.sv ====
// Contents undefined until written; same-word writes on both ports in one cycle keep port B
module reconfig_ram (
  input  logic                                   mgmt_clk,
  // Port A, sequencer side
  input  logic [reconfig_pkg::RAM_ADDR_BITS-1:0] a_address,
  input  logic                                   a_write,
  input  logic [reconfig_pkg::DATA_WIDTH-1:0]    a_writedata,
  output logic [reconfig_pkg::DATA_WIDTH-1:0]    a_readdata,
  // Port B, management side
  input  logic [reconfig_pkg::RAM_ADDR_BITS-1:0] b_address,
  input  logic                                   b_write,
  input  logic [reconfig_pkg::DATA_WIDTH-1:0]    b_writedata,
  output logic [reconfig_pkg::DATA_WIDTH-1:0]    b_readdata
);

  logic [reconfig_pkg::DATA_WIDTH-1:0] mem [reconfig_pkg::RAM_DEPTH];

  // ********************
  // Writes, both ports in one process
  always_ff @(posedge mgmt_clk) begin
    if (a_write) begin
      mem[a_address] <= a_writedata;
    end
    // Port B last so it wins a collision
    if (b_write) begin
      mem[b_address] <= b_writedata;
    end
  end

  // ********************
  // Registered reads, old data on a same-cycle write
  always_ff @(posedge mgmt_clk) begin
    a_readdata <= mem[a_address];
    b_readdata <= mem[b_address];
  end

endmodule

// ==== verilog/mgmt_wait_timer.sv ====
// Master must hold mgmt_read and the address until waitrequest falls; READ_WAIT_CYCLES >= 1
module mgmt_wait_timer (
  input  logic mgmt_clk,
  input  logic ctrl_reset,
  input  logic mgmt_read,
  output logic mgmt_waitrequest
);

  logic                                   started;
  logic [reconfig_pkg::WAIT_CNT_BITS-1:0] count;
  logic [reconfig_pkg::WAIT_CNT_BITS-1:0] remaining;

  // First read cycle sees the full load value before the counter is written
  assign remaining        = started ? count : reconfig_pkg::READ_WAIT_CYCLES;
  assign mgmt_waitrequest = mgmt_read && (remaining != '0);

  always_ff @(posedge mgmt_clk or posedge ctrl_reset) begin
    if (ctrl_reset) begin
      started <= 1'b0;
      count   <= '0;
    end else if (!mgmt_read) begin
      // Rearm once the read is dropped
      started <= 1'b0;
    end else if (!started) begin
      started <= 1'b1;
      // One wait cycle is already spent in this cycle
      count   <= reconfig_pkg::READ_WAIT_CYCLES - 4'd1;
    end else if (count != '0) begin
      count <= count - 4'd1;
    end
  end

endmodule

// ==== verilog/reconfig_pkg.sv ====
// ARB_COUNT must be a power of two so the IP index wraps on its own; all words are 32 bits
package reconfig_pkg;

  // ********************
  // Sizes
  localparam int ARB_COUNT       = 4;
  localparam int ARB_IDX_BITS    = 2;
  localparam int IP_WORDS        = 8;
  localparam int IP_ADDR_BITS    = 3;
  localparam int BASIC_ADDR_BITS = 3;
  localparam int DATA_WIDTH      = 32;

  // RAM holds one window of IP_WORDS per IP
  localparam int RAM_DEPTH      = ARB_COUNT * IP_WORDS;
  localparam int RAM_ADDR_BITS  = 5;
  // Upper bits pick the IP, lower bits the word
  localparam int MGMT_ADDR_BITS = 5;

  // ********************
  // Word offsets inside one IP window
  localparam logic [IP_ADDR_BITS-1:0] WORD_CMD    = 3'd0;
  localparam logic [IP_ADDR_BITS-1:0] WORD_DATA   = 3'd1;
  localparam logic [IP_ADDR_BITS-1:0] WORD_STATUS = 3'd2;
  localparam logic [IP_ADDR_BITS-1:0] WORD_RESULT = 3'd3;

  // Command word layout, basic address sits at bit 0
  localparam int CMD_OP_LSB = 8;
  localparam int OP_BITS    = 2;

  // Busy shows up here when a status word is read back
  localparam int STATUS_BUSY_BIT = 8;

  // Management read wait
  localparam int                      WAIT_CNT_BITS    = 4;
  localparam logic [WAIT_CNT_BITS-1:0] READ_WAIT_CYCLES = 4'd1;

  // ********************
  // Opcodes, spare behaves as OP_NONE
  typedef enum logic [OP_BITS-1:0] {
    OP_NONE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2,
    OP_SPARE = 2'd3
  } opcode_e;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE, FETCH_CMD, FETCH_DATA, REQUEST, ACCESS, STORE, DONE
  } seq_state_e;

endpackage
